/* verilog/icache_defs.svh */
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Fetch lanes, also the number of imshr entries
`define N 2

// Direct-mapped line array
`define CACHE_LINES 32
`define CACHE_LINE_BITS 5

// 16-bit address minus index and 3-bit offset
`define TAG_BITS 8

// Memory transaction tag width, zero means none
`define MEM_TAG_BITS 4

`define TRUE 1'b1
`define FALSE 1'b0

`endif

/* verilog/icache_pkg.sv */
`include "icache_defs.svh"

package icache_pkg;

    typedef logic [15:0] addr_t;
    typedef logic [63:0] mem_block_t;

    // Zero is never handed out by memory
    typedef logic [`MEM_TAG_BITS-1:0] mem_tag_t;

    typedef logic [`CACHE_LINE_BITS-1:0] cache_index_t;
    typedef logic [`TAG_BITS-1:0] cache_tag_t;

    // Shared with the data cache, stores never come from here
    typedef enum logic [1:0] {
        MEM_NONE  = 2'h0,
        MEM_LOAD  = 2'h1,
        MEM_STORE = 2'h2
    } mem_command_e;

    // MISS waits for the bus, WAIT waits for the data tag
    typedef enum logic [1:0] {
        IMSHR_INVALID = 2'h0,
        IMSHR_MISS    = 2'h1,
        IMSHR_WAIT    = 2'h2
    } imshr_state_e;

endpackage

/* verilog/psel_gen.sv */
module psel_gen #(
    parameter int WIDTH = 4,
    parameter int REQS = 1
) (
    input  logic [WIDTH-1:0]           req,
    output logic [WIDTH-1:0]           gnt,
    output logic [REQS-1:0][WIDTH-1:0] gnt_bus,
    output logic                       empty
);

    // Row k takes the k-th lowest set request
    always_comb begin
        int granted;
        granted = 0;
        gnt_bus = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (req[i] && granted < REQS) begin
                gnt_bus[granted][i] = 1'b1;
                granted++;
            end
        end
    end

    always_comb begin
        gnt = '0;
        for (int k = 0; k < REQS; k++) begin
            gnt = gnt | gnt_bus[k];
        end
    end

    assign empty = ~|req;

endmodule

/* verilog/imshr.sv */
`include "icache_defs.svh"

module imshr (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    dcache_request,
    input  icache_pkg::mem_tag_t                    mem2proc_transaction_tag,
    input  icache_pkg::mem_tag_t                    mem2proc_data_tag,
    input  icache_pkg::cache_index_t [`N-1:0]       miss_index,
    input  icache_pkg::cache_tag_t   [`N-1:0]       miss_tag,
    input  logic                     [`N-1:0]       miss_valid,
    output icache_pkg::addr_t                       proc2mem_addr,
    output icache_pkg::mem_command_e                proc2mem_command,
    output icache_pkg::cache_index_t                fill_index,
    output icache_pkg::cache_tag_t                  fill_tag,
    output logic                                    fill_ready
);

    icache_pkg::imshr_state_e state_q [`N];
    icache_pkg::imshr_state_e state_n [`N];
    icache_pkg::cache_index_t index_q [`N];
    icache_pkg::cache_index_t index_n [`N];
    icache_pkg::cache_tag_t   tag_q [`N];
    icache_pkg::cache_tag_t   tag_n [`N];
    icache_pkg::mem_tag_t     mem_tag_q [`N];
    icache_pkg::mem_tag_t     mem_tag_n [`N];

    logic [`N-1:0]         entry_free;
    logic [`N-1:0]         entry_miss;
    logic [`N-1:0]         merged;
    logic [`N-1:0][`N-1:0] free_gnt_bus;
    logic                  free_empty;
    logic [`N-1:0]         miss_gnt;
    logic                  miss_empty;

    always_comb begin
        for (int j = 0; j < `N; j++) begin
            entry_free[j] = state_q[j] == icache_pkg::IMSHR_INVALID;
            entry_miss[j] = state_q[j] == icache_pkg::IMSHR_MISS;
        end
    end

    // Duplicate of a live entry or of an earlier lane this cycle
    always_comb begin
        for (int i = 0; i < `N; i++) begin
            merged[i] = `FALSE;
            for (int j = 0; j < `N; j++) begin
                if (!entry_free[j] && index_q[j] == miss_index[i] && tag_q[j] == miss_tag[i]) begin
                    merged[i] = `TRUE;
                end
            end
            for (int k = 0; k < i; k++) begin
                if (miss_valid[k] && miss_index[k] == miss_index[i]
                        && miss_tag[k] == miss_tag[i]) begin
                    merged[i] = `TRUE;
                end
            end
        end
    end

    psel_gen #(
        .WIDTH(`N),
        .REQS(`N)
    ) u_free_sel (
        .req(entry_free),
        .gnt(),
        .gnt_bus(free_gnt_bus),
        .empty(free_empty)
    );

    psel_gen #(
        .WIDTH(`N),
        .REQS(1)
    ) u_miss_sel (
        .req(entry_miss),
        .gnt(miss_gnt),
        .gnt_bus(),
        .empty(miss_empty)
    );

    always_comb begin
        int alloc_cnt;
        alloc_cnt = 0;
        state_n = state_q;
        index_n = index_q;
        tag_n = tag_q;
        mem_tag_n = mem_tag_q;

        // Data return
        fill_index = '0;
        fill_tag = '0;
        fill_ready = `FALSE;
        for (int j = 0; j < `N; j++) begin
            if (state_q[j] == icache_pkg::IMSHR_WAIT && mem_tag_q[j] == mem2proc_data_tag
                    && mem2proc_data_tag != '0) begin
                fill_index = index_q[j];
                fill_tag = tag_q[j];
                fill_ready = `TRUE;
                state_n[j] = icache_pkg::IMSHR_INVALID;
            end
        end

        // New misses take free entries in lane order
        for (int i = 0; i < `N; i++) begin
            if (miss_valid[i] && !merged[i] && !free_empty) begin
                for (int j = 0; j < `N; j++) begin
                    if (free_gnt_bus[alloc_cnt][j]) begin
                        state_n[j] = icache_pkg::IMSHR_MISS;
                        index_n[j] = miss_index[i];
                        tag_n[j] = miss_tag[i];
                    end
                end
                alloc_cnt++;
            end
        end

        // Data cache owns the bus while it asks
        proc2mem_addr = '0;
        proc2mem_command = icache_pkg::MEM_NONE;
        if (!dcache_request && !miss_empty) begin
            for (int j = 0; j < `N; j++) begin
                if (miss_gnt[j]) begin
                    proc2mem_addr = {tag_q[j], index_q[j], 3'b000};
                    proc2mem_command = icache_pkg::MEM_LOAD;
                    if (mem2proc_transaction_tag != '0) begin
                        state_n[j] = icache_pkg::IMSHR_WAIT;
                        mem_tag_n[j] = mem2proc_transaction_tag;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int j = 0; j < `N; j++) begin
                state_q[j] <= icache_pkg::IMSHR_INVALID;
            end
        end else begin
            state_q <= state_n;
        end
    end

    always_ff @(posedge clock) begin
        index_q <= index_n;
        tag_q <= tag_n;
        mem_tag_q <= mem_tag_n;
    end

endmodule

/* verilog/icache_nb.sv */
`include "icache_defs.svh"

module icache_nb (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                squash,
    input  icache_pkg::mem_tag_t                mem2proc_transaction_tag,
    input  icache_pkg::mem_block_t              mem2proc_data,
    input  icache_pkg::mem_tag_t                mem2proc_data_tag,
    input  icache_pkg::addr_t        [`N-1:0]   proc2icache_addr,
    input  logic                     [`N-1:0]   valid,
    input  logic                                dcache_request,
    output icache_pkg::mem_command_e            proc2mem_command,
    output icache_pkg::addr_t                   proc2mem_addr,
    output icache_pkg::mem_block_t   [`N-1:0]   icache_data_out,
    output logic                     [`N-1:0]   icache_valid_out
);

    icache_pkg::mem_block_t line_data [`CACHE_LINES];
    icache_pkg::cache_tag_t line_tag [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] line_valid;

    icache_pkg::cache_index_t [`N-1:0] miss_index;
    icache_pkg::cache_tag_t   [`N-1:0] miss_tag;
    logic                     [`N-1:0] miss_valid;

    icache_pkg::cache_index_t fill_index;
    icache_pkg::cache_tag_t   fill_tag;
    logic                     fill_ready;
    logic                     imshr_reset;

    // Squash only drops pending misses, lines stay
    assign imshr_reset = reset | squash;

    imshr u_imshr (
        .clock(clock),
        .reset(imshr_reset),
        .dcache_request(dcache_request),
        .mem2proc_transaction_tag(mem2proc_transaction_tag),
        .mem2proc_data_tag(mem2proc_data_tag),
        .miss_index(miss_index),
        .miss_tag(miss_tag),
        .miss_valid(miss_valid),
        .proc2mem_addr(proc2mem_addr),
        .proc2mem_command(proc2mem_command),
        .fill_index(fill_index),
        .fill_tag(fill_tag),
        .fill_ready(fill_ready)
    );

    // Lookup per lane, same cycle
    always_comb begin
        for (int i = 0; i < `N; i++) begin
            {miss_tag[i], miss_index[i]} = proc2icache_addr[i][15:3];
            icache_valid_out[i] = valid[i] && line_valid[miss_index[i]]
                                  && line_tag[miss_index[i]] == miss_tag[i];
            icache_data_out[i] = icache_valid_out[i] ? line_data[miss_index[i]] : '0;
            miss_valid[i] = valid[i] && !icache_valid_out[i];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (fill_ready) begin
            line_valid[fill_index] <= 1'b1;
        end
    end

    // Fill overwrites whatever block held the index
    always_ff @(posedge clock) begin
        if (fill_ready) begin
            line_data[fill_index] <= mem2proc_data;
            line_tag[fill_index] <= fill_tag;
        end
    end

endmodule

/* tb/mem_model.sv */
module mem_model (
    input  logic                     clock,
    input  logic                     reset,
    input  icache_pkg::mem_command_e proc2mem_command,
    input  icache_pkg::addr_t        proc2mem_addr,
    output icache_pkg::mem_tag_t     mem2proc_transaction_tag,
    output icache_pkg::mem_block_t   mem2proc_data,
    output icache_pkg::mem_tag_t     mem2proc_data_tag,
    output int                       accepted_loads
);

    integer seed = 57;
    int cycle;
    int pending;
    logic refuse;
    icache_pkg::mem_tag_t next_tag;

    // Outstanding loads, oldest first
    icache_pkg::mem_tag_t pend_tag [$];
    icache_pkg::addr_t    pend_addr [$];
    int                   pend_due [$];

    assign mem2proc_transaction_tag =
        (proc2mem_command == icache_pkg::MEM_LOAD && !refuse && pending < 4) ? next_tag : '0;

    always @(posedge clock) begin
        if (reset) begin
            pend_tag.delete();
            pend_addr.delete();
            pend_due.delete();
            cycle <= 0;
            pending <= 0;
            refuse <= 1'b0;
            next_tag <= 1;
            accepted_loads <= 0;
            mem2proc_data <= '0;
            mem2proc_data_tag <= '0;
        end else begin
            if (mem2proc_transaction_tag != '0) begin
                pend_tag.push_back(mem2proc_transaction_tag);
                pend_addr.push_back(proc2mem_addr);
                pend_due.push_back(cycle + 4);
                next_tag <= (next_tag == 15) ? 1 : next_tag + 1;
                accepted_loads <= accepted_loads + 1;
            end
            // Data shows for one cycle only
            mem2proc_data_tag <= '0;
            if (pend_due.size() > 0 && pend_due[0] == cycle + 1) begin
                mem2proc_data <= {4{pend_addr[0]}};
                mem2proc_data_tag <= pend_tag[0];
                pend_tag.pop_front();
                pend_addr.pop_front();
                pend_due.pop_front();
            end
            pending <= pend_tag.size();
            // Roughly one load in four is turned away
            refuse <= ($random(seed) & 3) == 0;
            cycle <= cycle + 1;
        end
    end

endmodule

/* tb/icache_assertions.sv */
`include "icache_defs.svh"

module icache_assertions (
    input logic                     clock,
    input logic                     reset,
    input logic                     dcache_request,
    input icache_pkg::mem_command_e proc2mem_command,
    input logic                     fill_ready,
    input icache_pkg::imshr_state_e state_q [`N],
    input icache_pkg::cache_index_t index_q [`N],
    input icache_pkg::cache_tag_t   tag_q [`N]
);

    int assert_failures = 0;
    logic duplicate;

    always_comb begin
        duplicate = 1'b0;
        for (int a = 0; a < `N; a++) begin
            for (int b = a + 1; b < `N; b++) begin
                if (state_q[a] != icache_pkg::IMSHR_INVALID
                        && state_q[b] != icache_pkg::IMSHR_INVALID
                        && index_q[a] == index_q[b] && tag_q[a] == tag_q[b]) begin
                    duplicate = 1'b1;
                end
            end
        end
    end

    bus_yield: assert property (@(posedge clock) disable iff (reset)
        dcache_request |-> proc2mem_command == icache_pkg::MEM_NONE)
        else begin
            $error("load issued while the data cache owns the bus");
            assert_failures++;
        end

    unique_block: assert property (@(posedge clock) disable iff (reset) !duplicate)
        else begin
            $error("two live imshr entries track the same block");
            assert_failures++;
        end

    quiet_after_reset: assert property (@(posedge clock) reset |=> !fill_ready)
        else begin
            $error("fill_ready high right after reset");
            assert_failures++;
        end

endmodule

/* tb/icache_tb.sv */
`include "icache_defs.svh"

module icache_tb;

    localparam int PERIOD = 100;

    logic clock;
    logic reset;
    logic squash;
    logic dcache_request;
    icache_pkg::addr_t [`N-1:0]      proc2icache_addr;
    logic [`N-1:0]                   valid;
    icache_pkg::mem_tag_t            mem2proc_transaction_tag;
    icache_pkg::mem_block_t          mem2proc_data;
    icache_pkg::mem_tag_t            mem2proc_data_tag;
    icache_pkg::mem_command_e        proc2mem_command;
    icache_pkg::addr_t               proc2mem_addr;
    icache_pkg::mem_block_t [`N-1:0] icache_data_out;
    logic [`N-1:0]                   icache_valid_out;
    int accepted_loads;

    // One entry per test row
    string                      row_name [$];
    icache_pkg::addr_t [`N-1:0] row_addr [$];
    logic [`N-1:0]              row_valid [$];
    logic                       row_dcache [$];
    logic                       row_squash [$];
    int                         row_budget [$];
    logic                       row_done [$];
    int                         row_loads [$];
    logic table_ready;

    icache_nb u_dut (
        .clock(clock),
        .reset(reset),
        .squash(squash),
        .mem2proc_transaction_tag(mem2proc_transaction_tag),
        .mem2proc_data(mem2proc_data),
        .mem2proc_data_tag(mem2proc_data_tag),
        .proc2icache_addr(proc2icache_addr),
        .valid(valid),
        .dcache_request(dcache_request),
        .proc2mem_command(proc2mem_command),
        .proc2mem_addr(proc2mem_addr),
        .icache_data_out(icache_data_out),
        .icache_valid_out(icache_valid_out)
    );

    mem_model u_mem (
        .clock(clock),
        .reset(reset),
        .proc2mem_command(proc2mem_command),
        .proc2mem_addr(proc2mem_addr),
        .mem2proc_transaction_tag(mem2proc_transaction_tag),
        .mem2proc_data(mem2proc_data),
        .mem2proc_data_tag(mem2proc_data_tag),
        .accepted_loads(accepted_loads)
    );

    bind imshr icache_assertions u_assertions (
        .clock(clock),
        .reset(reset),
        .dcache_request(dcache_request),
        .proc2mem_command(proc2mem_command),
        .fill_ready(fill_ready),
        .state_q(state_q),
        .index_q(index_q),
        .tag_q(tag_q)
    );

    always #(PERIOD / 2) clock = ~clock;

    // Memory fills a block with its aligned address
    function automatic icache_pkg::mem_block_t block_pattern(input icache_pkg::addr_t a);
        return {4{a[15:3], 3'b000}};
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic add_row(input string name, input icache_pkg::addr_t a0,
                           input icache_pkg::addr_t a1, input logic [`N-1:0] v,
                           input logic dc, input logic sq, input int budget,
                           input logic done, input int loads);
        row_name.push_back(name);
        row_addr.push_back({a1, a0});
        row_valid.push_back(v);
        row_dcache.push_back(dc);
        row_squash.push_back(sq);
        row_budget.push_back(budget);
        row_done.push_back(done);
        row_loads.push_back(loads);
    endtask

    // A load count of -1 is not checked
    task automatic fill_table();
        add_row("cold_miss", 16'h1230, 16'h0000, 2'b01, 0, 0, 30, 1, 1);
        add_row("repeat_hit", 16'h1230, 16'h0000, 2'b01, 0, 0, 1, 1, 0);
        add_row("same_block", 16'h2468, 16'h246c, 2'b11, 0, 0, 30, 1, 1);
        add_row("two_blocks", 16'h4010, 16'h5020, 2'b11, 0, 0, 30, 1, 2);
        add_row("alias_a", 16'h6010, 16'h0000, 2'b01, 0, 0, 30, 1, 1);
        add_row("alias_b", 16'h4010, 16'h0000, 2'b01, 0, 0, 30, 1, 1);
        add_row("alias_a_again", 16'h6010, 16'h0000, 2'b01, 0, 0, 30, 1, 1);
        add_row("dcache_hold", 16'h7100, 16'h0000, 2'b01, 1, 0, 10, 0, 0);
        add_row("dcache_release", 16'h7100, 16'h0000, 2'b01, 0, 0, 30, 1, 1);
        add_row("squash_setup", 16'h8200, 16'h0000, 2'b01, 0, 0, 2, 0, -1);
        add_row("squash", 16'h8200, 16'h0000, 2'b01, 0, 1, 1, 0, -1);
        add_row("squash_refetch", 16'h8200, 16'h0000, 2'b01, 0, 0, 30, 1, 1);
    endtask

    task automatic run_row(input int r);
        int cycles;
        int loads_before;
        logic done;
        cycles = 0;
        done = 1'b0;
        loads_before = 0;
        while (!done && cycles < row_budget[r]) begin
            @(negedge clock);
            // Count starts after the previous row's last edge
            if (cycles == 0) begin
                loads_before = accepted_loads;
            end
            proc2icache_addr = row_addr[r];
            valid = row_valid[r];
            dcache_request = row_dcache[r];
            squash = row_squash[r];
            #(PERIOD / 4);
            for (int i = 0; i < `N; i++) begin
                if (icache_valid_out[i]) begin
                    check_value({row_name[r], " data"}, block_pattern(proc2icache_addr[i]),
                                icache_data_out[i]);
                end
            end
            if (row_done[r]) begin
                done = icache_valid_out == valid;
            end else begin
                check_value({row_name[r], " valid"}, 64'(0), 64'(icache_valid_out));
            end
            cycles++;
        end
        if (row_done[r] && !done) begin
            $display("row %s did not finish within %0d cycles", row_name[r], row_budget[r]);
            $display("tests failed");
            $fatal(1, "cycle budget exhausted");
        end
        if (row_loads[r] >= 0) begin
            check_value({row_name[r], " loads"}, 64'(row_loads[r]),
                        64'(accepted_loads - loads_before));
        end
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        squash = 1'b0;
        dcache_request = 1'b0;
        valid = '0;
        proc2icache_addr = '0;
        table_ready = 1'b0;
        fill_table();
        table_ready = 1'b1;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        foreach (row_name[r]) begin
            run_row(r);
        end
        @(negedge clock);
        valid = '0;
        if (u_dut.u_imshr.u_assertions.assert_failures == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("imshr assertions failed during the run");
            $display("tests failed");
            $fatal(1, "assertion failure");
        end
    end

    // Limit is every row budget plus some margin
    initial begin
        int limit;
        limit = 20;
        wait (table_ready);
        foreach (row_budget[r]) begin
            limit += row_budget[r];
        end
        #(limit * PERIOD);
        $display("watchdog expired after %0d cycles", limit);
        $display("tests failed");
        $fatal(1, "timeout");
    end

endmodule

/* project.f */
+incdir+verilog
verilog/icache_pkg.sv
verilog/psel_gen.sv
verilog/imshr.sv
verilog/icache_nb.sv
tb/mem_model.sv
tb/icache_assertions.sv
tb/icache_tb.sv

/* Bender.yml */
package:
  name: icache_nb

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/icache_pkg.sv
      - verilog/psel_gen.sv
      - verilog/imshr.sv
      - verilog/icache_nb.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/mem_model.sv
      - tb/icache_assertions.sv
      - tb/icache_tb.sv
